/* rename_core.f */
+incdir+source
source/rename_pkg.sv
source/decode_stage.sv
source/rename_map.sv
source/free_list.sv
source/rename_stage.sv
source/rename_core.sv
sim/tb_clock.sv
sim/rename_core_props.sv
sim/rename_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rename front end testbench with Verilator.
verilator --binary --timing --assert -Wno-fatal -f rename_core.f \
    --top-module rename_core_tb -o rename_core_sim \
    && ./obj_dir/rename_core_sim > sim.log 2>&1 \
    || echo "Some tests failed" >> sim.log
cat sim.log
if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0

/* sim/rename_core_props.sv */
`timescale 1ns/100ps
`include "rename_macros.svh"

module rename_core_props (
    input logic                                  clk,
    input logic                                  i_rst,
    input logic                                  i_squash,
    input logic [`RENAME_WIDTH-1:0]              i_rename_vld,
    input logic [`RENAME_WIDTH-1:0]              i_wr_en,
    input logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] i_new_prd,
    input rename_pkg::fl_state_e                 i_fl_state
);
    import rename_pkg::*;

    squash_clears_vld: assert property (@(posedge clk) disable iff (i_rst)
        i_squash |=> (i_rename_vld == '0))
        else $error("rename valid is still high in the cycle after a squash");

    // both lanes of one group never receive the same register.
    distinct_alloc: assert property (@(posedge clk) disable iff (i_rst)
        (i_wr_en == 2'b11) |-> (i_new_prd[0] != i_new_prd[1]))
        else $error("both lanes of a group were given the same physical register");

    no_alloc_in_recover: assert property (@(posedge clk) disable iff (i_rst)
        (i_fl_state == FL_RECOVER) |-> (i_wr_en == '0))
        else $error("a register was allocated while the free list was recovering");

endmodule

bind rename_stage rename_core_props i_rename_core_props (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_squash     (i_squash),
    .i_rename_vld (o_rename_vld),
    .i_wr_en      (wr_en),
    .i_new_prd    (new_prd),
    .i_fl_state   (u_free_list.fl_state)
);

/* sim/rename_core_tb.sv */
`timescale 1ns/100ps
`include "rename_macros.svh"

module rename_core_tb;
    import rename_pkg::*;

    localparam int NUM_OPS = 4000;

    logic                                      clk;
    logic                                      i_rst;
    logic [`RENAME_WIDTH-1:0]                  i_inst_vld;
    logic [`RENAME_WIDTH-1:0][`INST_W-1:0]     i_inst;
    logic                                      i_stall;
    logic                                      o_stall;
    logic                                      i_squash;
    logic [`RENAME_WIDTH-1:0]                  i_commit_vld;
    logic [`RENAME_WIDTH-1:0][`LREG_W-1:0]     i_commit_lrd;
    logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     i_commit_prd;
    logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     i_commit_prev_prd;
    logic [`RENAME_WIDTH-1:0]                  o_rename_vld;
    uop_kind_e [`RENAME_WIDTH-1:0]             o_kind;
    logic [`RENAME_WIDTH-1:0][`LREG_W-1:0]     o_lrd;
    logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     o_prd;
    logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     o_prev_prd;
    logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     o_prs1;
    logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     o_prs2;

    // reference state of the rename front end.
    logic [`PREG_W-1:0] m_spec   [`NUM_LREGS];
    logic [`PREG_W-1:0] m_commit [`NUM_LREGS];
    logic [`NUM_PREGS-1:0] m_free;
    logic [`NUM_PREGS-1:0] m_held;
    logic m_recover;
    logic [1:0] m_dec_vld;
    uop_kind_e m_dec_kind [2];
    logic [4:0] m_dec_rd [2];
    logic [4:0] m_dec_rs1 [2];
    logic [4:0] m_dec_rs2 [2];
    logic [1:0] m_out_vld;
    uop_kind_e m_out_kind [2];
    logic [4:0] m_out_lrd [2];
    logic [5:0] m_out_prd [2];
    logic [5:0] m_out_prev [2];
    logic [5:0] m_out_prs1 [2];
    logic [5:0] m_out_prs2 [2];
    // renamed writers that are not committed yet, as {lrd, prd, prev_prd}.
    logic [16:0] pending [$];

    logic [1:0] c_req;
    logic [1:0] c_wr_en;
    logic c_ok;
    logic c_stall;
    logic [5:0] c_new [2];
    logic [5:0] c_prev [2];
    logic [5:0] c_prs1 [2];
    logic [5:0] c_prs2 [2];

    int n_checks = 0;
    int n_errors = 0;
    int cycle = 0;
    logic checking = 1'b0;

    tb_clock i_tb_clock (.o_clk(clk));

    rename_core i_rename_core (.*);

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // RV32I field extraction with unused and x0 fields forced to zero.
    task automatic decode_word(input logic [31:0] w, output uop_kind_e kind,
                               output logic [4:0] rd, output logic [4:0] rs1,
                               output logic [4:0] rs2);
        case (w[6:0])
            7'b0110011: kind = OP_ALU;
            7'b0010011: kind = OP_ALU_IMM;
            7'b0000011: kind = OP_LOAD;
            7'b0100011: kind = OP_STORE;
            7'b1100011: kind = OP_BRANCH;
            default:    kind = OP_ILLEGAL;
        endcase
        rd  = (kind inside {OP_ALU, OP_ALU_IMM, OP_LOAD}) ? w[11:7] : 5'd0;
        rs1 = (kind != OP_ILLEGAL) ? w[19:15] : 5'd0;
        rs2 = (kind inside {OP_ALU, OP_STORE, OP_BRANCH}) ? w[24:20] : 5'd0;
    endtask

    function automatic logic [31:0] make_word();
        logic [6:0] opc;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        case ($urandom % 6)
            0: opc = 7'b0110011;
            1: opc = 7'b0010011;
            2: opc = 7'b0000011;
            3: opc = 7'b0100011;
            4: opc = 7'b1100011;
            default: opc = 7'($urandom);
        endcase
        // a narrow register range makes dependences inside a group common.
        rd  = ($urandom % 2) ? 5'($urandom % 4) : 5'($urandom);
        rs1 = ($urandom % 2) ? 5'($urandom % 4) : 5'($urandom);
        rs2 = ($urandom % 2) ? 5'($urandom % 4) : 5'($urandom);
        return {7'($urandom), rs2, rs1, 3'($urandom), rd, opc};
    endfunction

    // combinational view of the rename stage for the current inputs.
    task automatic eval_rename();
        int nfree;
        int nreq;
        logic [`NUM_PREGS-1:0] f;
        nfree = 0;
        nreq = 0;
        f = m_free;
        for (int p = 0; p < `NUM_PREGS; p++) begin
            nfree += int'(m_free[p]);
        end
        for (int l = 0; l < 2; l++) begin
            c_req[l] = m_dec_vld[l] && (m_dec_rd[l] != 0) && !i_stall;
            nreq += int'(c_req[l]);
        end
        c_ok = (nreq == 0) || (!m_recover && nfree >= nreq);
        c_stall = i_stall || !c_ok;
        for (int l = 0; l < 2; l++) begin
            c_new[l] = '0;
            if (c_req[l]) begin
                for (int p = `NUM_PREGS - 1; p >= 0; p--) begin
                    if (f[p]) begin
                        c_new[l] = 6'(p);
                    end
                end
                f[c_new[l]] = 1'b0;
            end
            c_wr_en[l] = c_req[l] && c_ok && !i_squash;
            c_prs1[l] = m_spec[m_dec_rs1[l]];
            c_prs2[l] = m_spec[m_dec_rs2[l]];
            c_prev[l] = m_spec[m_dec_rd[l]];
        end
        if (c_wr_en[0]) begin
            if (m_dec_rd[0] == m_dec_rs1[1]) c_prs1[1] = c_new[0];
            if (m_dec_rd[0] == m_dec_rs2[1]) c_prs2[1] = c_new[0];
            if (m_dec_rd[0] == m_dec_rd[1]) c_prev[1] = c_new[0];
        end
    endtask

    task automatic step_model();
        if (i_rst) begin
            for (int r = 0; r < `NUM_LREGS; r++) begin
                m_spec[r] = 6'(r);
                m_commit[r] = 6'(r);
            end
            m_free = {32'hffff_ffff, 32'h0};
            m_held = ~m_free;
            m_recover = 1'b0;
            m_dec_vld = '0;
            m_out_vld = '0;
            pending.delete();
            return;
        end
        eval_rename();
        if (i_squash) begin
            m_out_vld = '0;
        end else if (!i_stall) begin
            m_out_vld = c_ok ? m_dec_vld : 2'b00;
        end
        for (int l = 0; l < 2; l++) begin
            if (!i_stall) begin
                m_out_kind[l] = m_dec_kind[l];
                m_out_lrd[l] = m_dec_rd[l];
                m_out_prd[l] = c_new[l];
                m_out_prev[l] = c_prev[l];
                m_out_prs1[l] = c_prs1[l];
                m_out_prs2[l] = c_prs2[l];
            end
            if (c_wr_en[l]) begin
                pending.push_back({m_dec_rd[l], c_new[l], c_prev[l]});
                m_free[c_new[l]] = 1'b0;
            end
        end
        for (int l = 0; l < 2; l++) begin
            if (i_commit_vld[l]) begin
                m_commit[i_commit_lrd[l]] = i_commit_prd[l];
                m_held[i_commit_prd[l]] = 1'b1;
                m_held[i_commit_prev_prd[l]] = 1'b0;
                m_free[i_commit_prev_prd[l]] = 1'b1;
            end
        end
        if (m_recover) begin
            m_free = ~m_held;
        end
        m_free[0] = 1'b0;
        if (i_squash) begin
            m_spec = m_commit;
            pending.delete();
        end else begin
            for (int l = 0; l < 2; l++) begin
                if (c_wr_en[l]) m_spec[m_dec_rd[l]] = c_new[l];
            end
        end
        m_recover = i_squash;
        if (i_squash) begin
            m_dec_vld = '0;
        end else if (!c_stall) begin
            m_dec_vld = i_inst_vld;
        end
        if (!c_stall) begin
            for (int l = 0; l < 2; l++) begin
                decode_word(i_inst[l], m_dec_kind[l], m_dec_rd[l], m_dec_rs1[l], m_dec_rs2[l]);
            end
        end
    endtask

    always @(posedge clk) begin
        logic [16:0] e;
        int pct;
        step_model();
        if (!i_rst) begin
            cycle++;
            // alternate phases of slow and fast retirement to exhaust the free list.
            pct = ((cycle / 200) % 2 == 1) ? 5 : 70;
            i_commit_vld <= '0;
            // lane 1 is reached only when lane 0 commits, which keeps program order.
            for (int l = 0; l < 2; l++) begin
                if (pending.size() > 0 && ($urandom % 100) < pct) begin
                    e = pending.pop_front();
                    i_commit_vld[l] <= 1'b1;
                    i_commit_lrd[l] <= e[16:12];
                    i_commit_prd[l] <= e[11:6];
                    i_commit_prev_prd[l] <= e[5:0];
                end else begin
                    break;
                end
            end
            if (cycle < NUM_OPS) begin
                i_inst_vld <= 2'($urandom);
                i_inst[0] <= make_word();
                i_inst[1] <= make_word();
                i_stall <= ($urandom % 4 == 0);
                i_squash <= ($urandom % 64 == 0);
            end else begin
                i_inst_vld <= '0;
                i_stall <= 1'b0;
                i_squash <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (checking) begin
            eval_rename();
            check("o_stall", 32'(o_stall), 32'(c_stall));
            check("o_rename_vld", 32'(o_rename_vld), 32'(m_out_vld));
            for (int l = 0; l < 2; l++) begin
                if (m_out_vld[l]) begin
                    check($sformatf("o_kind[%0d]", l), 32'(o_kind[l]), 32'(m_out_kind[l]));
                    check($sformatf("o_lrd[%0d]", l), 32'(o_lrd[l]), 32'(m_out_lrd[l]));
                    check($sformatf("o_prd[%0d]", l), 32'(o_prd[l]), 32'(m_out_prd[l]));
                    check($sformatf("o_prev_prd[%0d]", l), 32'(o_prev_prd[l]),
                          32'(m_out_prev[l]));
                    check($sformatf("o_prs1[%0d]", l), 32'(o_prs1[l]), 32'(m_out_prs1[l]));
                    check($sformatf("o_prs2[%0d]", l), 32'(o_prs2[l]), 32'(m_out_prs2[l]));
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hbea4));
        i_rst <= 1'b1;
        i_inst_vld <= '0;
        i_inst <= '0;
        i_stall <= 1'b0;
        i_squash <= 1'b0;
        i_commit_vld <= '0;
        i_commit_lrd <= '0;
        i_commit_prd <= '0;
        i_commit_prev_prd <= '0;
        repeat (8) @(posedge clk);
        i_rst <= 1'b0;
        checking = 1'b1;
        repeat (NUM_OPS + 20) @(posedge clk);
        @(negedge clk);
        @(posedge clk);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (NUM_OPS * 40) @(posedge clk);
        $display("timeout, the run did not reach its end");
        $display("Some tests failed");
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter real PERIOD = 40.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #(PERIOD / 2.0);
        o_clk = ~o_clk;
    end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/100ps
`include "rename_macros.svh"

module decode_stage (
    input  logic                                     clk,
    input  logic                                     i_rst,
    input  logic                                     i_stall,
    input  logic                                     i_squash,
    input  logic [`RENAME_WIDTH-1:0]                 i_inst_vld,
    input  logic [`RENAME_WIDTH-1:0][`INST_W-1:0]    i_inst,
    output logic [`RENAME_WIDTH-1:0]                 o_vld,
    output rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0] o_kind,
    output logic [`RENAME_WIDTH-1:0][`LREG_W-1:0]    o_rd,
    output logic [`RENAME_WIDTH-1:0][`LREG_W-1:0]    o_rs1,
    output logic [`RENAME_WIDTH-1:0][`LREG_W-1:0]    o_rs2
);
    import rename_pkg::*;

    uop_kind_e [`RENAME_WIDTH-1:0]         kind;
    logic [`RENAME_WIDTH-1:0][`LREG_W-1:0] rd;
    logic [`RENAME_WIDTH-1:0][`LREG_W-1:0] rs1;
    logic [`RENAME_WIDTH-1:0][`LREG_W-1:0] rs2;

    // fields a kind does not read are zeroed so that they map to p0.
    always_comb begin
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            case (i_inst[l][6:0])
                7'b0110011: kind[l] = OP_ALU;
                7'b0010011: kind[l] = OP_ALU_IMM;
                7'b0000011: kind[l] = OP_LOAD;
                7'b0100011: kind[l] = OP_STORE;
                7'b1100011: kind[l] = OP_BRANCH;
                default:    kind[l] = OP_ILLEGAL;
            endcase
            rd[l]  = '0;
            rs1[l] = '0;
            rs2[l] = '0;
            if (kind[l] == OP_ALU || kind[l] == OP_ALU_IMM || kind[l] == OP_LOAD) begin
                rd[l] = i_inst[l][11:7];
            end
            if (kind[l] != OP_ILLEGAL) begin
                rs1[l] = i_inst[l][19:15];
            end
            if (kind[l] == OP_ALU || kind[l] == OP_STORE || kind[l] == OP_BRANCH) begin
                rs2[l] = i_inst[l][24:20];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_squash) begin
            o_vld <= '0;
        end else if (!i_stall) begin
            o_vld <= i_inst_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_kind <= kind;
            o_rd   <= rd;
            o_rs1  <= rs1;
            o_rs2  <= rs2;
        end
    end

endmodule

/* source/free_list.sv */
`timescale 1ns/100ps
`include "rename_macros.svh"

module free_list (
    input  logic                                  clk,
    input  logic                                  i_rst,
    input  logic                                  i_squash,
    input  logic [`RENAME_WIDTH-1:0]              i_req,
    output logic                                  o_can_alloc,
    output logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] o_prd,
    input  logic [`RENAME_WIDTH-1:0]              i_commit_vld,
    input  logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] i_commit_prd,
    input  logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] i_commit_prev_prd
);
    import rename_pkg::*;

    localparam logic [`NUM_PREGS-1:0] FREE_RST =
        {{(`NUM_PREGS-`NUM_LREGS){1'b1}}, {`NUM_LREGS{1'b0}}};

    fl_state_e                             fl_state;
    logic [`NUM_PREGS-1:0]                 free_map;
    logic [`NUM_PREGS-1:0]                 free_nxt;
    logic [`NUM_PREGS-1:0]                 held_map;
    logic [`NUM_PREGS-1:0]                 held_nxt;
    logic [`NUM_PREGS-1:0]                 second_mask;
    logic [`PREG_W:0]                      first_hit;
    logic [`PREG_W:0]                      second_hit;
    logic [$clog2(`RENAME_WIDTH+1)-1:0]    req_cnt;
    logic                                  alloc_en;

    // returns {found, index} of the lowest set bit.
    function automatic logic [`PREG_W:0] find_lowest(input logic [`NUM_PREGS-1:0] vec);
        logic [`PREG_W:0] hit;
        hit = '0;
        for (int i = `NUM_PREGS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                hit = {1'b1, i[`PREG_W-1:0]};
            end
        end
        return hit;
    endfunction

    always_comb begin
        second_mask = free_map;
        second_mask[first_hit[`PREG_W-1:0]] = 1'b0;
    end

    assign first_hit  = find_lowest(free_map);
    assign second_hit = find_lowest(second_mask);

    always_comb begin
        req_cnt = '0;
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            req_cnt = req_cnt + i_req[l];
        end
    end

    assign o_can_alloc = (fl_state == FL_RUN) &&
                         ((req_cnt == 0) ||
                          (req_cnt == 1 && first_hit[`PREG_W]) ||
                          (req_cnt == 2 && second_hit[`PREG_W]));
    assign alloc_en    = o_can_alloc && !i_squash;

    // lane 1 takes the lowest register only when lane 0 does not ask.
    assign o_prd[0] = first_hit[`PREG_W-1:0];
    assign o_prd[1] = i_req[0] ? second_hit[`PREG_W-1:0] : first_hit[`PREG_W-1:0];

    always_comb begin
        held_nxt = held_map;
        free_nxt = free_map;
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            if (alloc_en && i_req[l]) begin
                free_nxt[o_prd[l]] = 1'b0;
            end
        end
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            if (i_commit_vld[l]) begin
                held_nxt[i_commit_prd[l]]      = 1'b1;
                held_nxt[i_commit_prev_prd[l]] = 1'b0;
                free_nxt[i_commit_prev_prd[l]] = 1'b1;
            end
        end
        // whatever was in flight at the squash is lost, so only held registers stay busy.
        if (fl_state == FL_RECOVER) begin
            free_nxt = ~held_nxt;
        end
        free_nxt[0] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            fl_state <= FL_RUN;
            free_map <= FREE_RST;
            held_map <= ~FREE_RST;
        end else begin
            fl_state <= i_squash ? FL_RECOVER : FL_RUN;
            free_map <= free_nxt;
            held_map <= held_nxt;
        end
    end

endmodule

/* source/rename_core.sv */
`timescale 1ns/100ps
`include "rename_macros.svh"

module rename_core (
    input  logic                                      clk,
    input  logic                                      i_rst,
    input  logic [`RENAME_WIDTH-1:0]                  i_inst_vld,
    input  logic [`RENAME_WIDTH-1:0][`INST_W-1:0]     i_inst,
    input  logic                                      i_stall,
    output logic                                      o_stall,
    input  logic                                      i_squash,
    input  logic [`RENAME_WIDTH-1:0]                  i_commit_vld,
    input  logic [`RENAME_WIDTH-1:0][`LREG_W-1:0]     i_commit_lrd,
    input  logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     i_commit_prd,
    input  logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     i_commit_prev_prd,
    output logic [`RENAME_WIDTH-1:0]                  o_rename_vld,
    output rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0] o_kind,
    output logic [`RENAME_WIDTH-1:0][`LREG_W-1:0]     o_lrd,
    output logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     o_prd,
    output logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     o_prev_prd,
    output logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     o_prs1,
    output logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     o_prs2
);
    import rename_pkg::*;

    logic [`RENAME_WIDTH-1:0]              dec_vld;
    uop_kind_e [`RENAME_WIDTH-1:0]         dec_kind;
    logic [`RENAME_WIDTH-1:0][`LREG_W-1:0] dec_rd;
    logic [`RENAME_WIDTH-1:0][`LREG_W-1:0] dec_rs1;
    logic [`RENAME_WIDTH-1:0][`LREG_W-1:0] dec_rs2;

    // the combined rename stall also freezes the decode register.
    decode_stage u_decode_stage (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_stall    (o_stall),
        .i_squash   (i_squash),
        .i_inst_vld (i_inst_vld),
        .i_inst     (i_inst),
        .o_vld      (dec_vld),
        .o_kind     (dec_kind),
        .o_rd       (dec_rd),
        .o_rs1      (dec_rs1),
        .o_rs2      (dec_rs2)
    );

    rename_stage u_rename_stage (
        .clk               (clk),
        .i_rst             (i_rst),
        .i_stall           (i_stall),
        .i_squash          (i_squash),
        .o_stall           (o_stall),
        .i_vld             (dec_vld),
        .i_kind            (dec_kind),
        .i_rd              (dec_rd),
        .i_rs1             (dec_rs1),
        .i_rs2             (dec_rs2),
        .i_commit_vld      (i_commit_vld),
        .i_commit_lrd      (i_commit_lrd),
        .i_commit_prd      (i_commit_prd),
        .i_commit_prev_prd (i_commit_prev_prd),
        .o_rename_vld      (o_rename_vld),
        .o_kind            (o_kind),
        .o_lrd             (o_lrd),
        .o_prd             (o_prd),
        .o_prev_prd        (o_prev_prd),
        .o_prs1            (o_prs1),
        .o_prs2            (o_prs2)
    );

endmodule

/* source/rename_macros.svh */
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// lanes in one rename group, lane 0 is the oldest.
`define RENAME_WIDTH 2

// logical register file, x0 to x31.
`define NUM_LREGS 32
`define LREG_W 5

// physical register file.
`define NUM_PREGS 64
`define PREG_W 6

// width of one instruction word.
`define INST_W 32

`endif

/* source/rename_map.sv */
`timescale 1ns/100ps
`include "rename_macros.svh"

module rename_map (
    input  logic                                  clk,
    input  logic                                  i_rst,
    input  logic                                  i_squash,
    input  logic [`RENAME_WIDTH-1:0]              i_wr_en,
    input  logic [`RENAME_WIDTH-1:0][`LREG_W-1:0] i_rd,
    input  logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] i_new_prd,
    input  logic [`RENAME_WIDTH-1:0][`LREG_W-1:0] i_rs1,
    input  logic [`RENAME_WIDTH-1:0][`LREG_W-1:0] i_rs2,
    output logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] o_prs1,
    output logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] o_prs2,
    output logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] o_prev_prd,
    input  logic [`RENAME_WIDTH-1:0]              i_commit_vld,
    input  logic [`RENAME_WIDTH-1:0][`LREG_W-1:0] i_commit_lrd,
    input  logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] i_commit_prd
);

    logic [`PREG_W-1:0] spec_map   [`NUM_LREGS];
    logic [`PREG_W-1:0] commit_map [`NUM_LREGS];
    logic [`PREG_W-1:0] commit_nxt [`NUM_LREGS];

    // committed view after this cycle's commits, also the squash restore source.
    always_comb begin
        commit_nxt = commit_map;
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            if (i_commit_vld[l]) begin
                commit_nxt[i_commit_lrd[l]] = i_commit_prd[l];
            end
        end
    end

    // an older lane in the group that writes the register overrides the table.
    // the youngest such lane wins, which matters once the group is wider than two.
    always_comb begin
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            o_prs1[l]     = spec_map[i_rs1[l]];
            o_prs2[l]     = spec_map[i_rs2[l]];
            o_prev_prd[l] = spec_map[i_rd[l]];
            for (int j = 0; j < l; j++) begin
                if (i_wr_en[j] && i_rd[j] == i_rs1[l]) begin
                    o_prs1[l] = i_new_prd[j];
                end
                if (i_wr_en[j] && i_rd[j] == i_rs2[l]) begin
                    o_prs2[l] = i_new_prd[j];
                end
                if (i_wr_en[j] && i_rd[j] == i_rd[l]) begin
                    o_prev_prd[l] = i_new_prd[j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int r = 0; r < `NUM_LREGS; r++) begin
                spec_map[r]   <= r[`PREG_W-1:0];
                commit_map[r] <= r[`PREG_W-1:0];
            end
        end else begin
            commit_map <= commit_nxt;
            if (i_squash) begin
                spec_map <= commit_nxt;
            end else begin
                // later lanes are written last so they win on a shared rd.
                for (int l = 0; l < `RENAME_WIDTH; l++) begin
                    if (i_wr_en[l]) begin
                        spec_map[i_rd[l]] <= i_new_prd[l];
                    end
                end
            end
        end
    end

endmodule

/* source/rename_pkg.sv */
package rename_pkg;

    // micro-op class derived from the RV32I major opcode.
    typedef enum logic [2:0] {
        OP_ALU     = 3'd0,
        OP_ALU_IMM = 3'd1,
        OP_LOAD    = 3'd2,
        OP_STORE   = 3'd3,
        OP_BRANCH  = 3'd4,
        OP_ILLEGAL = 3'd5
    } uop_kind_e;

    // the free list spends one cycle rebuilding itself after a squash.
    typedef enum logic {
        FL_RUN     = 1'b0,
        FL_RECOVER = 1'b1
    } fl_state_e;

endpackage

/* source/rename_stage.sv */
`timescale 1ns/100ps
`include "rename_macros.svh"

module rename_stage (
    input  logic                                      clk,
    input  logic                                      i_rst,
    input  logic                                      i_stall,
    input  logic                                      i_squash,
    output logic                                      o_stall,
    input  logic [`RENAME_WIDTH-1:0]                  i_vld,
    input  rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0] i_kind,
    input  logic [`RENAME_WIDTH-1:0][`LREG_W-1:0]     i_rd,
    input  logic [`RENAME_WIDTH-1:0][`LREG_W-1:0]     i_rs1,
    input  logic [`RENAME_WIDTH-1:0][`LREG_W-1:0]     i_rs2,
    input  logic [`RENAME_WIDTH-1:0]                  i_commit_vld,
    input  logic [`RENAME_WIDTH-1:0][`LREG_W-1:0]     i_commit_lrd,
    input  logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     i_commit_prd,
    input  logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     i_commit_prev_prd,
    output logic [`RENAME_WIDTH-1:0]                  o_rename_vld,
    output rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0] o_kind,
    output logic [`RENAME_WIDTH-1:0][`LREG_W-1:0]     o_lrd,
    output logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     o_prd,
    output logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     o_prev_prd,
    output logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     o_prs1,
    output logic [`RENAME_WIDTH-1:0][`PREG_W-1:0]     o_prs2
);

    logic [`RENAME_WIDTH-1:0]              has_rd;
    logic [`RENAME_WIDTH-1:0]              req;
    logic [`RENAME_WIDTH-1:0]              wr_en;
    logic                                  can_alloc;
    logic                                  rename_ok;
    logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] alloc_prd;
    logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] new_prd;
    logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] prev_prd;
    logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] prs1;
    logic [`RENAME_WIDTH-1:0][`PREG_W-1:0] prs2;

    always_comb begin
        for (int l = 0; l < `RENAME_WIDTH; l++) begin
            has_rd[l]  = i_vld[l] && (i_rd[l] != '0);
            req[l]     = has_rd[l] && !i_stall;
            new_prd[l] = has_rd[l] ? alloc_prd[l] : '0;
        end
    end

    // a group with no destination never waits on the free list.
    assign rename_ok = can_alloc || !(|req);
    assign o_stall   = i_stall || !rename_ok;
    assign wr_en     = req & {`RENAME_WIDTH{rename_ok && !i_squash}};

    rename_map u_rename_map (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_squash     (i_squash),
        .i_wr_en      (wr_en),
        .i_rd         (i_rd),
        .i_new_prd    (new_prd),
        .i_rs1        (i_rs1),
        .i_rs2        (i_rs2),
        .o_prs1       (prs1),
        .o_prs2       (prs2),
        .o_prev_prd   (prev_prd),
        .i_commit_vld (i_commit_vld),
        .i_commit_lrd (i_commit_lrd),
        .i_commit_prd (i_commit_prd)
    );

    free_list u_free_list (
        .clk               (clk),
        .i_rst             (i_rst),
        .i_squash          (i_squash),
        .i_req             (req),
        .o_can_alloc       (can_alloc),
        .o_prd             (alloc_prd),
        .i_commit_vld      (i_commit_vld),
        .i_commit_prd      (i_commit_prd),
        .i_commit_prev_prd (i_commit_prev_prd)
    );

    always_ff @(posedge clk) begin
        if (i_rst || i_squash) begin
            o_rename_vld <= '0;
        end else if (!i_stall) begin
            o_rename_vld <= rename_ok ? i_vld : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_kind     <= i_kind;
            o_lrd      <= i_rd;
            o_prd      <= new_prd;
            o_prev_prd <= prev_prd;
            o_prs1     <= prs1;
            o_prs2     <= prs2;
        end
    end

endmodule
